//--- source/axi_lite_pkg.sv
package axi_lite_pkg;

	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0]  axi_strb_t;
	typedef logic [2:0]  axi_size_t;
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;

	// Transfer size codes, log2 of the byte count.
	localparam axi_size_t SIZE_1B = 3'b000;
	localparam axi_size_t SIZE_2B = 3'b001;
	localparam axi_size_t SIZE_4B = 3'b010;

	typedef struct packed {
		axi_addr_t addr;
		axi_size_t size;
	} axi_ar_t;

	typedef struct packed {
		axi_data_t data;
		axi_resp_t resp;
	} axi_r_t;

	typedef struct packed {
		axi_addr_t addr;
		axi_size_t size;
	} axi_aw_t;

	typedef struct packed {
		axi_data_t data;
		axi_strb_t strb;
	} axi_w_t;

	typedef struct packed {
		axi_resp_t resp;
	} axi_b_t;

endpackage

//--- source/lsu_pkg.sv
package lsu_pkg;

	typedef logic [31:0] word_t;

	// RV32E has 16 integer registers.
	typedef logic [3:0] reg_idx_t;

	typedef logic [2:0] funct3_t;

	localparam funct3_t F3_B  = 3'b000;
	localparam funct3_t F3_H  = 3'b001;
	localparam funct3_t F3_W  = 3'b010;
	localparam funct3_t F3_BU = 3'b100;
	localparam funct3_t F3_HU = 3'b101;

	// Data RAM geometry, in 32-bit words.
	localparam int RAM_WORDS = 1024;
	localparam int RAM_IDX_W = 10;

	typedef struct packed {
		reg_idx_t rd;
		logic     reg_wen;
		funct3_t  funct3;
		word_t    exu_val;
		word_t    store_data;
		logic     ren;
		logic     wen;
	} lsu_req_t;

	typedef struct packed {
		reg_idx_t rd;
		logic     reg_wen;
		word_t    value;
	} lsu_wb_t;

	// What both memory ports need to see while an access is in flight.
	typedef struct packed {
		axi_lite_pkg::axi_addr_t addr;
		funct3_t                 funct3;
		word_t                   store_data;
	} mem_ctx_t;

endpackage

//--- source/lsu_read_port.sv
`timescale 1ns/10ps

module lsu_read_port (
	input  logic                  clock,
	input  logic                  rst_n,

	input  lsu_pkg::mem_ctx_t     ctx,
	input  logic                  rd_start,

	output axi_lite_pkg::axi_ar_t ar,
	output logic                  arvalid,
	input  logic                  arready,
	input  axi_lite_pkg::axi_r_t  r,
	input  logic                  rvalid,
	output logic                  rready,

	output logic                  load_done,
	output lsu_pkg::word_t        load_val
);

	logic           ar_hold_q;
	logic           r_beat;
	lsu_pkg::word_t lane_val;
	lsu_pkg::word_t ext_val;

	// The start pulse itself raises arvalid, so the request goes out the
	// cycle after acceptance; the hold flag keeps it up through a stall.
	assign arvalid = rd_start | ar_hold_q;
	assign ar.addr = ctx.addr;
	assign ar.size = {1'b0, ctx.funct3[1:0]};

	assign rready = 1'b1;
	assign r_beat = rvalid & rready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ar_hold_q <= 1'b0;
		end else begin
			ar_hold_q <= arvalid & ~arready;
		end
	end

	// Bring the addressed lane down to bit 0.
	assign lane_val = r.data >> {ctx.addr[1:0], 3'b000};

	always_comb begin
		case (ctx.funct3)
			lsu_pkg::F3_B:  ext_val = {{24{lane_val[7]}}, lane_val[7:0]};
			lsu_pkg::F3_H:  ext_val = {{16{lane_val[15]}}, lane_val[15:0]};
			lsu_pkg::F3_W:  ext_val = lane_val;
			lsu_pkg::F3_BU: ext_val = {24'h0, lane_val[7:0]};
			lsu_pkg::F3_HU: ext_val = {16'h0, lane_val[15:0]};
			default:        ext_val = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			load_done <= 1'b0;
		end else begin
			load_done <= r_beat;
		end
	end

	always_ff @(posedge clock) begin
		if (r_beat) begin
			load_val <= ext_val;
		end
	end

endmodule

//--- source/lsu_write_port.sv
`timescale 1ns/10ps

module lsu_write_port (
	input  logic                  clock,
	input  logic                  rst_n,

	input  lsu_pkg::mem_ctx_t     ctx,
	input  logic                  wr_start,

	output axi_lite_pkg::axi_aw_t aw,
	output logic                  awvalid,
	input  logic                  awready,
	output axi_lite_pkg::axi_w_t  w,
	output logic                  wvalid,
	input  logic                  wready,
	input  axi_lite_pkg::axi_b_t  b,
	input  logic                  bvalid,
	output logic                  bready,

	output logic                  store_done
);

	logic                    aw_hold_q;
	logic                    w_hold_q;
	axi_lite_pkg::axi_strb_t mask;

	// Both channels open on the start pulse and close on their own handshake.
	assign awvalid = wr_start | aw_hold_q;
	assign wvalid  = wr_start | w_hold_q;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			aw_hold_q <= 1'b0;
			w_hold_q  <= 1'b0;
		end else begin
			aw_hold_q <= awvalid & ~awready;
			w_hold_q  <= wvalid & ~wready;
		end
	end

	assign aw.addr = ctx.addr;
	assign aw.size = {1'b0, ctx.funct3[1:0]};

	always_comb begin
		case (aw.size)
			axi_lite_pkg::SIZE_1B: mask = 4'b0001;
			axi_lite_pkg::SIZE_2B: mask = 4'b0011;
			axi_lite_pkg::SIZE_4B: mask = 4'b1111;
			default:               mask = 4'b0000;
		endcase
	end

	// Lanes come from the low address bits only, so a halfword at offset 3
	// simply loses its upper byte.
	assign w.strb = mask << ctx.addr[1:0];
	assign w.data = ctx.store_data << {ctx.addr[1:0], 3'b000};

	assign bready = 1'b1;

	// The response code is always OKAY from this RAM and is not examined.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			store_done <= 1'b0;
		end else begin
			store_done <= bvalid & bready;
		end
	end

endmodule

//--- source/lsu_stage_ctrl.sv
`timescale 1ns/10ps

module lsu_stage_ctrl (
	input  logic              clock,
	input  logic              rst_n,

	input  lsu_pkg::lsu_req_t req,
	input  logic              req_valid,
	output logic              req_ready,

	output lsu_pkg::mem_ctx_t ctx,
	output logic              rd_start,
	output logic              wr_start,

	input  logic              load_done,
	input  lsu_pkg::word_t    load_val,
	input  logic              store_done,

	output lsu_pkg::lsu_wb_t  wb,
	output logic              wb_valid
);

	logic              accept;
	logic              pass_q;
	logic              is_load_q;
	lsu_pkg::reg_idx_t rd_q;
	logic              reg_wen_q;

	assign accept = req_valid & req_ready;

	// Control flags. Exactly one of the three completions fires per request.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			req_ready <= 1'b1;
			rd_start  <= 1'b0;
			wr_start  <= 1'b0;
			pass_q    <= 1'b0;
			is_load_q <= 1'b0;
		end else begin
			rd_start <= accept & req.ren;
			wr_start <= accept & req.wen;
			pass_q   <= accept & ~req.ren & ~req.wen;
			if (accept) begin
				is_load_q <= req.ren;
			end
			if (accept) begin
				req_ready <= 1'b0;
			end else if (wb_valid) begin
				req_ready <= 1'b1;
			end
		end
	end

	// Issue register. It stays put until the next acceptance, which covers
	// the whole time the ports are working on it.
	always_ff @(posedge clock) begin
		if (accept) begin
			rd_q           <= req.rd;
			reg_wen_q      <= req.reg_wen;
			ctx.addr       <= req.exu_val;
			ctx.funct3     <= req.funct3;
			ctx.store_data <= req.store_data;
		end
	end

	assign wb_valid = pass_q | load_done | store_done;

	assign wb.rd      = rd_q;
	assign wb.reg_wen = reg_wen_q;
	// The execute value doubles as the address, so it sits in ctx.addr.
	assign wb.value   = is_load_q ? load_val : ctx.addr;

endmodule

//--- source/data_ram.sv
`timescale 1ns/10ps

module data_ram (
	input  logic                  clock,
	input  logic                  rst_n,

	input  axi_lite_pkg::axi_ar_t ar,
	input  logic                  arvalid,
	output logic                  arready,
	output axi_lite_pkg::axi_r_t  r,
	output logic                  rvalid,
	input  logic                  rready,

	input  axi_lite_pkg::axi_aw_t aw,
	input  logic                  awvalid,
	output logic                  awready,
	input  axi_lite_pkg::axi_w_t  w,
	input  logic                  wvalid,
	output logic                  wready,
	output axi_lite_pkg::axi_b_t  b,
	output logic                  bvalid,
	input  logic                  bready
);

	axi_lite_pkg::axi_data_t mem [lsu_pkg::RAM_WORDS];

	logic                    ar_hs;
	logic                    aw_hs;
	logic                    w_hs;
	logic                    aw_full_q;
	logic                    w_full_q;
	axi_lite_pkg::axi_addr_t awaddr_q;
	axi_lite_pkg::axi_w_t    wbeat_q;
	axi_lite_pkg::axi_addr_t waddr;
	axi_lite_pkg::axi_w_t    wbeat;
	logic                    do_write;
	axi_lite_pkg::axi_data_t rdata_q;

	assign arready = ~rvalid;
	assign awready = ~aw_full_q & ~bvalid;
	assign wready  = ~w_full_q & ~bvalid;

	assign ar_hs = arvalid & arready;
	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;

	// A beat arriving now is used directly so that the write and b follow
	// in the same cycle as the later of the two handshakes.
	assign waddr    = aw_full_q ? awaddr_q : aw.addr;
	assign wbeat    = w_full_q ? wbeat_q : w;
	assign do_write = (aw_full_q | aw_hs) & (w_full_q | w_hs);

	assign r.data = rdata_q;
	assign r.resp = axi_lite_pkg::RESP_OKAY;
	assign b.resp = axi_lite_pkg::RESP_OKAY;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rvalid    <= 1'b0;
			bvalid    <= 1'b0;
			aw_full_q <= 1'b0;
			w_full_q  <= 1'b0;
		end else begin
			if (ar_hs) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (do_write) begin
				bvalid    <= 1'b1;
				aw_full_q <= 1'b0;
				w_full_q  <= 1'b0;
			end else begin
				if (bready) begin
					bvalid <= 1'b0;
				end
				aw_full_q <= aw_full_q | aw_hs;
				w_full_q  <= w_full_q | w_hs;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_hs) begin
			awaddr_q <= aw.addr;
		end
		if (w_hs) begin
			wbeat_q <= w;
		end
		if (ar_hs) begin
			rdata_q <= mem[ar.addr[lsu_pkg::RAM_IDX_W+1:2]];
		end
		for (int i = 0; i < 4; i++) begin
			if (do_write && wbeat.strb[i]) begin
				mem[waddr[lsu_pkg::RAM_IDX_W+1:2]][8*i +: 8] <= wbeat.data[8*i +: 8];
			end
		end
	end

endmodule

//--- source/lsu_top.sv
`timescale 1ns/10ps

module lsu_top (
	input  logic              clock,
	input  logic              rst_n,
	input  lsu_pkg::lsu_req_t req,
	input  logic              req_valid,
	output logic              req_ready,
	output lsu_pkg::lsu_wb_t  wb,
	output logic              wb_valid
);

	lsu_pkg::mem_ctx_t     ctx;
	logic                  rd_start;
	logic                  wr_start;
	logic                  load_done;
	lsu_pkg::word_t        load_val;
	logic                  store_done;

	axi_lite_pkg::axi_ar_t ar;
	logic                  arvalid;
	logic                  arready;
	axi_lite_pkg::axi_r_t  r;
	logic                  rvalid;
	logic                  rready;
	axi_lite_pkg::axi_aw_t aw;
	logic                  awvalid;
	logic                  awready;
	axi_lite_pkg::axi_w_t  w;
	logic                  wvalid;
	logic                  wready;
	axi_lite_pkg::axi_b_t  b;
	logic                  bvalid;
	logic                  bready;

	lsu_stage_ctrl ctrl_i (
		.clock(clock), .rst_n(rst_n),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.ctx(ctx), .rd_start(rd_start), .wr_start(wr_start),
		.load_done(load_done), .load_val(load_val), .store_done(store_done),
		.wb(wb), .wb_valid(wb_valid)
	);

	lsu_read_port rd_port_i (
		.clock(clock), .rst_n(rst_n), .ctx(ctx), .rd_start(rd_start),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.load_done(load_done), .load_val(load_val)
	);

	lsu_write_port wr_port_i (
		.clock(clock), .rst_n(rst_n), .ctx(ctx), .wr_start(wr_start),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.store_done(store_done)
	);

	data_ram ram_i (
		.clock(clock), .rst_n(rst_n),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready)
	);

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clock
);

	localparam int HALF_PERIOD = 4;

	initial begin
		clock = 1'b0;
	end

	always begin
		#HALF_PERIOD clock = ~clock;
	end

endmodule

//--- tb/lsu_tb_checks.svh
`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

task automatic abort_run(input string why);
	$display("%s", why);
	$display("FAIL: see errors above");
	$fatal(1, "run stopped at the first error");
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
	if (got !== exp) begin
		abort_run($sformatf("FAIL at %0t ns: %s expected %b got %b", $time, name, exp, got));
	end
endtask

task automatic check_count(input string name, input int exp, input int got);
	if (got != exp) begin
		abort_run($sformatf("FAIL at %0t ns: %s expected %0d got %0d", $time, name, exp, got));
	end
endtask

// Store writebacks carry no defined value, so with_value skips that field.
task automatic check_wb(input string name, input lsu_pkg::lsu_wb_t exp,
		input lsu_pkg::lsu_wb_t got, input bit with_value);
	if (got.rd !== exp.rd) begin
		abort_run($sformatf("FAIL at %0t ns: %s.rd expected %0d got %0d",
			$time, name, exp.rd, got.rd));
	end
	if (got.reg_wen !== exp.reg_wen) begin
		abort_run($sformatf("FAIL at %0t ns: %s.reg_wen expected %b got %b",
			$time, name, exp.reg_wen, got.reg_wen));
	end
	if (with_value && got.value !== exp.value) begin
		abort_run($sformatf("FAIL at %0t ns: %s.value expected %h got %h",
			$time, name, exp.value, got.value));
	end
endtask

function automatic lsu_pkg::lsu_req_t make_req(input lsu_pkg::reg_idx_t rd,
		input logic reg_wen, input lsu_pkg::funct3_t f3, input lsu_pkg::word_t exu_val,
		input lsu_pkg::word_t store_data, input logic ren, input logic wen);
	lsu_pkg::lsu_req_t r;
	r.rd         = rd;
	r.reg_wen    = reg_wen;
	r.funct3     = f3;
	r.exu_val    = exu_val;
	r.store_data = store_data;
	r.ren        = ren;
	r.wen        = wen;
	return r;
endfunction

// Called on a falling edge. Returns the wb record and the number of cycles
// from the accepting edge to the wb_valid cycle.
task automatic issue_req(input lsu_pkg::lsu_req_t r, input bit hold,
		output lsu_pkg::lsu_wb_t got, output int lat);
	int waited;
	waited = 0;
	req       = r;
	req_valid = 1'b1;
	while (!req_ready) begin
		@(negedge clock);
		waited++;
		if (waited > WAIT_LIMIT) begin
			abort_run("The stage never raised req_ready for a waiting request.");
		end
	end
	@(negedge clock);
	if (!hold) begin
		req_valid = 1'b0;
	end
	lat = 1;
	while (!wb_valid) begin
		check_bit("req_ready", 1'b0, req_ready);
		if (lat >= WAIT_LIMIT) begin
			abort_run("wb_valid did not arrive within 20 cycles of acceptance.");
		end
		@(negedge clock);
		lat++;
	end
	got = wb;
	check_bit("req_ready", 1'b0, req_ready);
	@(negedge clock);
	check_bit("wb_valid", 1'b0, wb_valid);
	check_bit("req_ready", 1'b1, req_ready);
endtask

`endif

//--- tb/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int REQ_COUNT = 57;
	localparam int WAIT_LIMIT = 20;

	logic              clock;
	logic              rst_n;
	lsu_pkg::lsu_req_t req;
	logic              req_valid;
	logic              req_ready;
	lsu_pkg::lsu_wb_t  wb;
	logic              wb_valid;

	// Byte image of the data RAM.
	logic [7:0] model [4 * lsu_pkg::RAM_WORDS];

	tb_clock clk_i (.clock(clock));

	lsu_top dut_i (
		.clock(clock), .rst_n(rst_n),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.wb(wb), .wb_valid(wb_valid)
	);

	`include "lsu_tb_checks.svh"

	// Bytes that fall past lane 3 are dropped, as the lanes wrap nowhere.
	function automatic void model_store(input lsu_pkg::word_t addr,
			input lsu_pkg::funct3_t f3, input lsu_pkg::word_t data);
		int nbytes;
		int lane;
		int base;
		nbytes = 1 << f3[1:0];
		base   = 4 * int'(addr[lsu_pkg::RAM_IDX_W+1:2]);
		for (int i = 0; i < nbytes; i++) begin
			lane = int'(addr[1:0]) + i;
			if (lane < 4) begin
				model[base + lane] = data[8*i +: 8];
			end
		end
	endfunction

	function automatic lsu_pkg::word_t model_load(input lsu_pkg::word_t addr,
			input lsu_pkg::funct3_t f3);
		int             base;
		int             off;
		logic [7:0]     lo;
		logic [7:0]     hi;
		lsu_pkg::word_t word;
		base = 4 * int'(addr[lsu_pkg::RAM_IDX_W+1:2]);
		off  = int'(addr[1:0]);
		lo   = model[base + off];
		hi   = (off < 3) ? model[base + off + 1] : 8'h00;
		word = {model[base + 3], model[base + 2], model[base + 1], model[base]};
		case (f3)
			lsu_pkg::F3_B:  return {{24{lo[7]}}, lo};
			lsu_pkg::F3_BU: return {24'h0, lo};
			lsu_pkg::F3_H:  return {{16{hi[7]}}, hi, lo};
			lsu_pkg::F3_HU: return {16'h0, hi, lo};
			default:        return word;
		endcase
	endfunction

	function automatic lsu_pkg::lsu_wb_t expect_wb(input lsu_pkg::lsu_req_t r,
			input lsu_pkg::word_t value);
		lsu_pkg::lsu_wb_t e;
		e.rd      = r.rd;
		e.reg_wen = r.reg_wen;
		e.value   = value;
		return e;
	endfunction

	function automatic lsu_pkg::word_t random_word_addr();
		return lsu_pkg::word_t'($urandom_range(0, lsu_pkg::RAM_WORDS - 1)) << 2;
	endfunction

	task automatic do_store(input lsu_pkg::word_t addr, input lsu_pkg::funct3_t f3,
			input lsu_pkg::word_t data);
		lsu_pkg::lsu_req_t r;
		lsu_pkg::lsu_wb_t  got;
		int                lat;
		r = make_req(4'd0, 1'b0, f3, addr, data, 1'b0, 1'b1);
		model_store(addr, f3, data);
		issue_req(r, 1'b0, got, lat);
		check_wb("store wb", expect_wb(r, 32'h0), got, 1'b0);
		check_count("store latency", 3, lat);
	endtask

	task automatic do_load(input lsu_pkg::word_t addr, input lsu_pkg::funct3_t f3,
			input lsu_pkg::reg_idx_t rd);
		lsu_pkg::lsu_req_t r;
		lsu_pkg::lsu_wb_t  got;
		int                lat;
		r = make_req(rd, 1'b1, f3, addr, 32'h0, 1'b1, 1'b0);
		issue_req(r, 1'b0, got, lat);
		check_wb("load wb", expect_wb(r, model_load(addr, f3)), got, 1'b1);
		check_count("load latency", 3, lat);
	endtask

	task automatic test_pass_through();
		lsu_pkg::lsu_req_t r;
		lsu_pkg::lsu_wb_t  got;
		int                lat;
		check_bit("req_ready", 1'b1, req_ready);
		check_bit("wb_valid", 1'b0, wb_valid);
		r = make_req(4'd5, 1'b1, lsu_pkg::F3_W, $urandom(), $urandom(), 1'b0, 1'b0);
		issue_req(r, 1'b0, got, lat);
		check_wb("pass wb", expect_wb(r, r.exu_val), got, 1'b1);
		check_count("pass-through latency", 1, lat);
	endtask

	task automatic test_word_round_trip();
		lsu_pkg::word_t addr;
		for (int i = 0; i < 8; i++) begin
			addr = random_word_addr();
			do_store(addr, lsu_pkg::F3_W, $urandom());
			do_load(addr, lsu_pkg::F3_W, lsu_pkg::reg_idx_t'(i + 1));
		end
	endtask

	task automatic test_narrow_stores();
		lsu_pkg::word_t addr;
		addr = random_word_addr();
		for (int lane = 0; lane < 4; lane++) begin
			do_store(addr + lane, lsu_pkg::F3_B, $urandom());
		end
		do_load(addr, lsu_pkg::F3_W, 4'd3);
		do_store(addr, lsu_pkg::F3_H, $urandom());
		do_store(addr + 2, lsu_pkg::F3_H, $urandom());
		do_load(addr, lsu_pkg::F3_W, 4'd4);
	endtask

	task automatic test_narrow_loads();
		lsu_pkg::word_t addr;
		lsu_pkg::word_t data;
		for (int top = 0; top < 2; top++) begin
			addr = random_word_addr();
			data = $urandom();
			data = top ? (data | 32'h8080_8080) : (data & 32'h7f7f_7f7f);
			do_store(addr, lsu_pkg::F3_W, data);
			for (int lane = 0; lane < 4; lane++) begin
				do_load(addr + lane, lsu_pkg::F3_B, 4'd6);
				do_load(addr + lane, lsu_pkg::F3_BU, 4'd7);
			end
			for (int off = 0; off < 4; off += 2) begin
				do_load(addr + off, lsu_pkg::F3_H, 4'd8);
				do_load(addr + off, lsu_pkg::F3_HU, 4'd9);
			end
		end
	endtask

	task automatic test_back_to_back();
		lsu_pkg::word_t    addr;
		lsu_pkg::word_t    exp_val;
		lsu_pkg::reg_idx_t rd;
		lsu_pkg::lsu_req_t r;
		lsu_pkg::lsu_wb_t  got;
		int                lat;
		addr = random_word_addr();
		for (int i = 0; i < 6; i++) begin
			rd = lsu_pkg::reg_idx_t'(i + 1);
			case (i % 3)
				0:       r = make_req(rd, 1'b0, lsu_pkg::F3_W, addr, $urandom(), 1'b0, 1'b1);
				1:       r = make_req(rd, 1'b1, lsu_pkg::F3_W, addr, 32'h0, 1'b1, 1'b0);
				default: r = make_req(rd, 1'b1, lsu_pkg::F3_W, $urandom(), 32'h0, 1'b0, 1'b0);
			endcase
			if (r.wen) begin
				model_store(r.exu_val, r.funct3, r.store_data);
			end
			exp_val = r.ren ? model_load(r.exu_val, r.funct3) : r.exu_val;
			issue_req(r, 1'b1, got, lat);
			check_wb("back-to-back wb", expect_wb(r, exp_val), got, !r.wen);
			check_count("back-to-back latency", (r.ren | r.wen) ? 3 : 1, lat);
		end
		req_valid = 1'b0;
	endtask

	initial begin
		#((REQ_COUNT * 10 + RESET_CYCLES + 100) * CLK_PERIOD);
		abort_run("The watchdog expired before the test sequence finished.");
	end

	initial begin
		void'($urandom(32'hd4e92809));
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		test_pass_through();
		test_word_round_trip();
		test_narrow_stores();
		test_narrow_loads();
		test_back_to_back();
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- sources.f
+incdir+tb
source/axi_lite_pkg.sv
source/lsu_pkg.sv
source/lsu_read_port.sv
source/lsu_write_port.sv
source/lsu_stage_ctrl.sv
source/data_ram.sv
source/lsu_top.sv
tb/tb_clock.sv
tb/lsu_tb.sv
